/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_control_unit
SEED      ?= 81725
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) SEED=$(SEED) LOG=$(LOG)"

test:
	$(VERILATOR) --binary --timing -f compile.f --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_control_unit.sv */
module tb_control_unit #(
    parameter int SEED = 81725
);
    import ctrl_pkg::*;

    localparam int NUM_OPS        = 254; // Directed 54 plus 200 random.
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 100;

    typedef struct packed {
        insn_class_e cls;
        ctrl_word_t  ctrl;
        logic [3:0]  mem_starts;
        logic [3:0]  fp_starts;
        logic        fixed_latency;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        dispatch;
    logic [31:0] insn;
    flags_t      flags;
    logic        memory_done;
    logic        done_fp;
    ctrl_word_t  ctrl;
    logic        done;
    logic        busy;
    logic        illegal;

    int errors = 0;
    int cycles = 0;
    int sent_legal;
    int sent_illegal;
    int done_cnt;
    int illegal_cnt;

    logic        op_active;
    logic [31:0] op_insn;
    int          op_cycles;
    ctrl_word_t  acc;
    int          mem_cnt;
    int          fp_cnt;
    logic        illegal_due;
    expect_t     accepted;

    control_unit i_control_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .dispatch    (dispatch),
        .insn        (insn),
        .flags       (flags),
        .memory_done (memory_done),
        .done_fp     (done_fp),
        .ctrl        (ctrl),
        .done        (done),
        .busy        (busy),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h at cycle %0d",
                     name, expected, actual, cycles);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic expect_t expect_op(input logic [31:0] word, input flags_t f);
        expect_t    e;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       taken;
        e     = '0;
        opc   = word[6:0];
        f3    = word[14:12];
        f7    = word[31:25];
        taken = 1'b0;
        case (opc)
            OP, OP_IMM: begin
                e.cls               = CLASS_ALU;
                e.fixed_latency     = 1'b1;
                e.ctrl.load_rs1     = 1'b1;
                e.ctrl.load_rs2     = 1'b1;
                e.ctrl.load_imm     = 1'b1;
                e.ctrl.load_alu     = 1'b1;
                e.ctrl.load_regfile = 1'b1;
                e.ctrl.load_pc      = 1'b1;
                e.ctrl.sel_alu_b    = opc == OP_IMM;
                e.ctrl.sub_sra      = f7[5] && ((opc == OP && f3 == 3'b000) || f3 == 3'b101);
                e.ctrl.sel_rd       = SEL_RD_ALU;
            end
            BRANCH, JAL, JALR: begin
                case (f3)
                    3'b000:  taken = f.eq;
                    3'b001:  taken = !f.eq;
                    3'b100:  taken = f.ls;
                    3'b101:  taken = !f.ls;
                    3'b110:  taken = f.lu;
                    3'b111:  taken = !f.lu;
                    default: taken = 1'b0;
                endcase
                if (opc != BRANCH) begin
                    taken = 1'b1; // Jumps are always taken.
                end
                e.cls                   = CLASS_BRANCH_JUMP;
                e.fixed_latency         = 1'b1;
                e.ctrl.load_rs1         = 1'b1;
                e.ctrl.load_rs2         = 1'b1;
                e.ctrl.load_imm         = 1'b1;
                e.ctrl.load_pc_alu      = 1'b1;
                e.ctrl.load_flags       = 1'b1;
                e.ctrl.load_pc          = 1'b1;
                e.ctrl.sel_pc_increment = 1'b1;
                e.ctrl.sel_pc_jump      = taken;
                e.ctrl.load_regfile     = opc != BRANCH;
                e.ctrl.sel_pc_next      = opc == JALR;
                e.ctrl.sel_rd           = SEL_RD_LINK;
            end
            LOAD, STORE, LOAD_FP, STORE_FP: begin
                e.cls                    = CLASS_LOAD_STORE;
                e.mem_starts             = 4'd1;
                e.ctrl.load_rs1          = 1'b1;
                e.ctrl.load_imm          = 1'b1;
                e.ctrl.load_alu          = 1'b1;
                e.ctrl.memory_start      = 1'b1;
                e.ctrl.load_pc           = 1'b1;
                e.ctrl.sel_alu_b         = 1'b1;
                e.ctrl.load_rs2          = opc == STORE;
                e.ctrl.load_rs2_fp       = opc == STORE_FP;
                e.ctrl.sel_store_fp      = opc == STORE_FP;
                e.ctrl.sel_mem_operation = opc == STORE || opc == STORE_FP;
                e.ctrl.load_data_memory  = opc == LOAD || opc == LOAD_FP;
                e.ctrl.load_regfile      = opc == LOAD;
                e.ctrl.sel_rd            = (opc == LOAD) ? SEL_RD_MEM : SEL_RD_NONE;
                e.ctrl.load_fp_regfile   = opc == LOAD_FP;
                e.ctrl.sel_rd_fp         = opc == LOAD_FP;
            end
            OP_FP: begin
                if (f7 == FADD || f7 == FSUB || f7 == FMUL) begin
                    e.cls                   = CLASS_FP_OP;
                    e.fp_starts             = 4'd1;
                    e.ctrl.load_rs1_fp      = 1'b1;
                    e.ctrl.load_rs2_fp      = 1'b1;
                    e.ctrl.start_mult_fp    = f7 == FMUL;
                    e.ctrl.start_add_sub_fp = f7 != FMUL;
                    e.ctrl.sub_fp           = f7 == FSUB;
                    e.ctrl.load_alu_fp      = 1'b1;
                    e.ctrl.load_fp_regfile  = 1'b1;
                    e.ctrl.load_pc          = 1'b1;
                end
            end
            default: e.cls = CLASS_IDLE;
        endcase
        return e;
    endfunction

    function automatic logic [31:0] make_insn(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [6:0] opc);
        logic [31:0] r;
        r = $urandom;
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    function automatic logic [31:0] random_legal_insn();
        logic [31:0] w;
        logic [2:0]  f3;
        int          n;
        w = '0;
        n = int'($urandom_range(0, 5));
        case ($urandom_range(0, 3))
            0: begin
                f3 = 3'($urandom_range(0, 7));
                w  = make_insn({1'b0, 1'($urandom_range(0, 1)), 5'd0}, f3,
                               $urandom_range(0, 1) ? OP : OP_IMM);
                if (f3 != 3'b000 && f3 != 3'b101) begin
                    w[30] = 1'b0;
                end
            end
            1: begin
                if ($urandom_range(0, 3) == 0) begin
                    w = make_insn(7'($urandom), 3'b000, $urandom_range(0, 1) ? JAL : JALR);
                end else begin
                    w = make_insn(7'($urandom), 3'(n < 2 ? n : n + 2), BRANCH);
                end
            end
            2: begin
                case (n % 4)
                    0:       w = make_insn(7'($urandom), 3'b010, LOAD);
                    1:       w = make_insn(7'($urandom), 3'b010, STORE);
                    2:       w = make_insn(7'($urandom), 3'b010, LOAD_FP);
                    default: w = make_insn(7'($urandom), 3'b010, STORE_FP);
                endcase
            end
            default: begin
                case (n % 3)
                    0:       w = make_insn(FADD, 3'b111, OP_FP);
                    1:       w = make_insn(FSUB, 3'b111, OP_FP);
                    default: w = make_insn(FMUL, 3'b111, OP_FP);
                endcase
            end
        endcase
        return w;
    endfunction

    // Dispatch one instruction, then wait until the unit is free again.
    task automatic send_op(input logic [31:0] word, input bit poke);
        expect_t    e;
        logic [2:0] f;
        f        = 3'($urandom_range(0, 7));
        e        = expect_op(word, f);
        dispatch = 1'b1;
        insn     = word;
        flags    = f;
        if (e.cls == CLASS_IDLE) begin
            sent_illegal++;
        end else begin
            sent_legal++;
        end
        @(posedge clk);
        #1;
        dispatch = 1'b0;
        while (busy) begin
            if (poke && $urandom_range(0, 3) == 0) begin
                dispatch = 1'b1; // Must be ignored while busy.
                insn     = random_legal_insn();
            end else begin
                dispatch = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        dispatch = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Responders and compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int delay;
        memory_done = 1'b0;
        forever begin
            @(negedge clk);
            if (ctrl.memory_start) begin
                delay = int'($urandom_range(1, 6));
                repeat (delay) @(posedge clk);
                #1 memory_done = 1'b1;
                @(posedge clk);
                #1 memory_done = 1'b0;
            end
        end
    end

    initial begin
        int delay;
        done_fp = 1'b0;
        forever begin
            @(negedge clk);
            if (ctrl.start_add_sub_fp || ctrl.start_mult_fp) begin
                delay = int'($urandom_range(1, 8));
                repeat (delay) @(posedge clk);
                #1 done_fp = 1'b1;
                @(posedge clk);
                #1 done_fp = 1'b0;
            end
        end
    end

    task automatic finish_op();
        expect_t e;
        e = expect_op(op_insn, flags);
        check_value("ctrl", 32'(e.ctrl), 32'(acc));
        check_value("memory_start count", 32'(e.mem_starts), mem_cnt);
        check_value("fp start count", 32'(e.fp_starts), fp_cnt);
        if (e.fixed_latency) begin
            check_value("done cycle", 32'd3, op_cycles);
        end
        done_cnt++;
        op_active = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            op_active   = 1'b0;
            illegal_due = 1'b0;
            done_cnt    = 0;
            illegal_cnt = 0;
        end else begin
            check_value("illegal", 32'(illegal_due), 32'(illegal));
            if (illegal) begin
                illegal_cnt++;
            end
            illegal_due = 1'b0;
            if (op_active) begin
                op_cycles++;
                acc = acc | ctrl; // Strobes seen from dispatch to done.
                if (ctrl.memory_start) begin
                    mem_cnt++;
                end
                if (ctrl.start_add_sub_fp || ctrl.start_mult_fp) begin
                    fp_cnt++;
                end
                check_value("busy", 32'd1, 32'(busy));
                if (done) begin
                    finish_op();
                end
            end else begin
                check_value("ctrl", 32'd0, 32'(ctrl));
                check_value("done", 32'd0, 32'(done));
                check_value("busy", 32'd0, 32'(busy));
                if (dispatch) begin
                    accepted = expect_op(insn, flags);
                    if (accepted.cls == CLASS_IDLE) begin
                        illegal_due = 1'b1;
                    end else begin
                        op_active = 1'b1;
                        op_insn   = insn;
                        op_cycles = 0;
                        acc       = '0;
                        mem_cnt   = 0;
                        fp_cnt    = 0;
                    end
                end
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        dispatch     = 1'b0;
        insn         = '0;
        flags        = '0;
        sent_legal   = 0;
        sent_illegal = 0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (10) @(posedge clk); // Nothing dispatched, outputs stay low.
        #1;

        send_op(make_insn(7'h00, 3'b000, OP), 1'b0);
        send_op(make_insn(7'h20, 3'b000, OP), 1'b0);
        send_op(make_insn(7'h20, 3'b101, OP), 1'b0);
        send_op(make_insn(7'h20, 3'b101, OP_IMM), 1'b0);
        send_op(make_insn(7'h7f, 3'b000, OP_IMM), 1'b0); // Negative immediate, no subtract.

        for (int n = 0; n < 6; n++) begin
            repeat (4) send_op(make_insn(7'($urandom), 3'(n < 2 ? n : n + 2), BRANCH), 1'b0);
        end
        send_op(make_insn(7'($urandom), 3'($urandom), JAL), 1'b0);
        send_op(make_insn(7'($urandom), 3'b000, JALR), 1'b0);

        repeat (3) begin
            send_op(make_insn(7'($urandom), 3'b010, LOAD), 1'b0);
            send_op(make_insn(7'($urandom), 3'b010, STORE), 1'b0);
            send_op(make_insn(7'($urandom), 3'b010, LOAD_FP), 1'b0);
            send_op(make_insn(7'($urandom), 3'b010, STORE_FP), 1'b0);
        end

        repeat (3) begin
            send_op(make_insn(FADD, 3'b111, OP_FP), 1'b0);
            send_op(make_insn(FSUB, 3'b111, OP_FP), 1'b0);
            send_op(make_insn(FMUL, 3'b111, OP_FP), 1'b0);
        end

        send_op(make_insn(7'h00, 3'b000, 7'b0001111), 1'b0);
        repeat (3) @(posedge clk);
        #1;
        send_op(make_insn(7'b0101100, 3'b111, OP_FP), 1'b0); // Square root is not supported.
        repeat (3) @(posedge clk);
        #1;

        repeat (200) send_op(random_legal_insn(), 1'b1);

        repeat (10) @(posedge clk);
        check_value("done count", sent_legal, done_cnt);
        check_value("illegal count", sent_illegal, illegal_cnt);
        $display("Summary: %0d errors, %0d operations done, %0d illegal rejected",
                 errors, done_cnt, illegal_cnt);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/ctrl_pkg.sv
hw/insn_classifier.sv
hw/fsm_alu.sv
hw/fsm_branch_jump.sv
hw/fsm_load_store.sv
hw/fsm_fp_op.sv
hw/fsm_combined.sv
hw/control_unit.sv
bench/tb_control_unit.sv

/* hw/control_unit.sv */
module control_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dispatch,
    input  logic [31:0]          insn,
    input  ctrl_pkg::flags_t     flags,
    input  logic                 memory_done,
    input  logic                 done_fp,
    output ctrl_pkg::ctrl_word_t ctrl,
    output logic                 done,
    output logic                 busy,
    output logic                 illegal
);
    import ctrl_pkg::*;

    logic [NUM_UNITS-1:0] start;
    logic [31:0]          insn_q;
    ctrl_word_t           alu_ctrl;
    ctrl_word_t           bj_ctrl;
    ctrl_word_t           ls_ctrl;
    ctrl_word_t           fp_ctrl;
    logic                 alu_done;
    logic                 bj_done;
    logic                 ls_done;
    logic                 fp_done;

    assign busy = |start;

    insn_classifier i_insn_classifier (
        .clk      (clk),
        .rst_n    (rst_n),
        .dispatch (dispatch),
        .insn     (insn),
        .done     (done),
        .start    (start),
        .insn_q   (insn_q),
        .illegal  (illegal)
    );

    fsm_alu i_fsm_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start[UNIT_ALU]),
        .insn_q (insn_q),
        .ctrl   (alu_ctrl),
        .done   (alu_done)
    );

    fsm_branch_jump i_fsm_branch_jump (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start[UNIT_BJ]),
        .insn_q (insn_q),
        .flags  (flags),
        .ctrl   (bj_ctrl),
        .done   (bj_done)
    );

    fsm_load_store i_fsm_load_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start[UNIT_LS]),
        .insn_q      (insn_q),
        .memory_done (memory_done),
        .ctrl        (ls_ctrl),
        .done        (ls_done)
    );

    fsm_fp_op i_fsm_fp_op (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start[UNIT_FP]),
        .insn_q  (insn_q),
        .done_fp (done_fp),
        .ctrl    (fp_ctrl),
        .done    (fp_done)
    );

    fsm_combined i_fsm_combined (
        .start    (start),
        .insn_q   (insn_q),
        .alu_ctrl (alu_ctrl),
        .alu_done (alu_done),
        .bj_ctrl  (bj_ctrl),
        .bj_done  (bj_done),
        .ls_ctrl  (ls_ctrl),
        .ls_done  (ls_done),
        .fp_ctrl  (fp_ctrl),
        .fp_done  (fp_done),
        .ctrl     (ctrl),
        .done     (done)
    );

endmodule

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        LOAD     = 7'b0000011,
        LOAD_FP  = 7'b0000111,
        OP_IMM   = 7'b0010011,
        STORE    = 7'b0100011,
        STORE_FP = 7'b0100111,
        OP       = 7'b0110011,
        OP_FP    = 7'b1010011,
        BRANCH   = 7'b1100011,
        JALR     = 7'b1100111,
        JAL      = 7'b1101111
    } opcode_e;

    typedef enum logic [6:0] {
        FADD = 7'b0000000,
        FSUB = 7'b0000100,
        FMUL = 7'b0001000
    } fp_funct_e;

    typedef enum logic [2:0] {
        CLASS_IDLE,
        CLASS_ALU,
        CLASS_BRANCH_JUMP,
        CLASS_LOAD_STORE,
        CLASS_FP_OP
    } insn_class_e;

    localparam int NUM_UNITS = 4;
    localparam int UNIT_ALU  = 0;
    localparam int UNIT_BJ   = 1;
    localparam int UNIT_LS   = 2;
    localparam int UNIT_FP   = 3;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [1:0] SEL_RD_NONE = 2'd0;
    localparam logic [1:0] SEL_RD_MEM  = 2'd1;
    localparam logic [1:0] SEL_RD_ALU  = 2'd2;
    localparam logic [1:0] SEL_RD_LINK = 2'd3; // Writes PC+4 to rd.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath interface
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic lu; // Unsigned less than.
        logic ls; // Signed less than.
        logic eq;
    } flags_t;

    typedef struct packed {
        logic [1:0] sel_rd;
        logic       sub_sra;
        logic       sel_pc_next;
        logic       sel_alu_a;
        logic       sel_alu_b;
        logic       load_pc_alu;
        logic       load_flags;
        logic       sel_pc_increment;
        logic       sel_pc_jump;
        logic       sel_alu_32b;
        logic       load_pc;
        logic       load_regfile;
        logic       load_rs1;
        logic       load_rs2;
        logic       load_alu;
        logic       load_imm;
        logic       load_rs1_fp;
        logic       load_rs2_fp;
        logic       load_fp_regfile;
        logic       sel_store_fp;
        logic       sel_rd_fp;
        logic       start_add_sub_fp;
        logic       start_mult_fp;
        logic       load_alu_fp;
        logic       sub_fp;
        logic       load_data_memory;
        logic       memory_start;
        logic       sel_mem_next;
        logic       sel_mem_operation;
    } ctrl_word_t;

endpackage

/* hw/fsm_alu.sv */
module fsm_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [31:0]          insn_q,
    output ctrl_pkg::ctrl_word_t ctrl,
    output logic                 done
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {IDLE, DECODE, EXECUTE, WRITEBACK} state_e;

    state_e  state_q;
    state_e  state;
    state_e  state_d;
    opcode_e opcode;
    logic    is_sub;
    logic    is_sra;

    assign opcode = opcode_e'(insn_q[6:0]);
    assign is_sub = (opcode == OP) && (insn_q[14:12] == F3_ADD_SUB); // SUB has no immediate form.
    assign is_sra = insn_q[14:12] == F3_SRL_SRA;

    // DECODE starts in the same cycle as the start level.
    assign state = (state_q == IDLE && start) ? DECODE : state_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = IDLE;
        ctrl    = '0;
        done    = 1'b0;
        case (state)
            DECODE: begin
                ctrl.load_rs1 = 1'b1;
                ctrl.load_rs2 = 1'b1;
                ctrl.load_imm = 1'b1;
                state_d       = EXECUTE;
            end
            EXECUTE: begin
                ctrl.load_alu  = 1'b1;
                ctrl.sel_alu_b = opcode == OP_IMM;
                ctrl.sub_sra   = insn_q[30] && (is_sub || is_sra); // Funct7 bit 5.
                state_d        = WRITEBACK;
            end
            WRITEBACK: begin
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc      = 1'b1;
                done              = 1'b1;
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

/* hw/fsm_branch_jump.sv */
module fsm_branch_jump (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [31:0]          insn_q,
    input  ctrl_pkg::flags_t     flags,
    output ctrl_pkg::ctrl_word_t ctrl,
    output logic                 done
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {IDLE, DECODE, COMPARE, UPDATE} state_e;

    state_e  state_q;
    state_e  state;
    state_e  state_d;
    opcode_e opcode;
    logic    is_jump;
    logic    taken;

    assign opcode  = opcode_e'(insn_q[6:0]);
    assign is_jump = (opcode == JAL) || (opcode == JALR);
    assign state   = (state_q == IDLE && start) ? DECODE : state_q;

    always_comb begin
        case (insn_q[14:12])
            F3_BEQ:  taken = flags.eq;
            F3_BNE:  taken = !flags.eq;
            F3_BLT:  taken = flags.ls;
            F3_BGE:  taken = !flags.ls;
            F3_BLTU: taken = flags.lu;
            F3_BGEU: taken = !flags.lu;
            default: taken = 1'b0;
        endcase
        if (is_jump) begin
            taken = 1'b1; // JALR carries funct3 000, so jumps override the table.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = IDLE;
        ctrl    = '0;
        done    = 1'b0;
        case (state)
            DECODE: begin
                ctrl.load_rs1    = 1'b1;
                ctrl.load_rs2    = 1'b1;
                ctrl.load_imm    = 1'b1;
                ctrl.load_pc_alu = 1'b1; // Target address computed here.
                state_d          = COMPARE;
            end
            COMPARE: begin
                ctrl.load_flags = 1'b1;
                state_d         = UPDATE;
            end
            UPDATE: begin
                ctrl.load_pc          = 1'b1;
                ctrl.sel_pc_increment = 1'b1;
                ctrl.sel_pc_jump      = taken;
                ctrl.load_regfile     = is_jump; // Link register write.
                ctrl.sel_pc_next      = opcode == JALR;
                done                  = 1'b1;
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

/* hw/fsm_combined.sv */
module fsm_combined (
    input  logic [ctrl_pkg::NUM_UNITS-1:0] start,
    input  logic [31:0]                    insn_q,
    input  ctrl_pkg::ctrl_word_t           alu_ctrl,
    input  logic                           alu_done,
    input  ctrl_pkg::ctrl_word_t           bj_ctrl,
    input  logic                           bj_done,
    input  ctrl_pkg::ctrl_word_t           ls_ctrl,
    input  logic                           ls_done,
    input  ctrl_pkg::ctrl_word_t           fp_ctrl,
    input  logic                           fp_done,
    output ctrl_pkg::ctrl_word_t           ctrl,
    output logic                           done
);
    import ctrl_pkg::*;

    insn_class_e index;
    ctrl_word_t  selected;
    ctrl_word_t  fixed;

    always_comb begin
        case (start)
            4'b0001: index = CLASS_ALU;
            4'b0010: index = CLASS_BRANCH_JUMP;
            4'b0100: index = CLASS_LOAD_STORE;
            4'b1000: index = CLASS_FP_OP;
            default: index = CLASS_IDLE; // Idle or a corrupt start word.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Selection plus fields held for the whole class
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        selected = '0;
        fixed    = '0;
        done     = 1'b0;
        case (index)
            CLASS_ALU: begin
                selected     = alu_ctrl;
                done         = alu_done;
                fixed.sel_rd = SEL_RD_ALU;
            end
            CLASS_BRANCH_JUMP: begin
                selected     = bj_ctrl;
                done         = bj_done;
                fixed.sel_rd = SEL_RD_LINK;
            end
            CLASS_LOAD_STORE: begin
                selected           = ls_ctrl;
                done               = ls_done;
                fixed.sel_alu_b    = 1'b1; // Address is base plus offset.
                fixed.sel_store_fp = opcode_e'(insn_q[6:0]) == STORE_FP;
            end
            CLASS_FP_OP: begin
                selected = fp_ctrl;
                done     = fp_done;
            end
            default: done = 1'b0;
        endcase
    end

    assign ctrl = selected | fixed;

endmodule

/* hw/fsm_fp_op.sv */
module fsm_fp_op (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [31:0]          insn_q,
    input  logic                 done_fp,
    output ctrl_pkg::ctrl_word_t ctrl,
    output logic                 done
);
    import ctrl_pkg::*;

    typedef enum logic [2:0] {IDLE, DECODE, FP_START, FP_WAIT, FINISH} state_e;

    state_e state_q;
    state_e state;
    state_e state_d;
    logic   is_mul;
    logic   is_sub;

    assign is_mul = insn_q[31:25] == FMUL;
    assign is_sub = insn_q[31:25] == FSUB;
    assign state  = (state_q == IDLE && start) ? DECODE : state_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = IDLE;
        ctrl    = '0;
        done    = 1'b0;
        case (state)
            DECODE: begin
                ctrl.load_rs1_fp = 1'b1;
                ctrl.load_rs2_fp = 1'b1;
                state_d          = FP_START;
            end
            FP_START: begin
                ctrl.start_mult_fp    = is_mul;
                ctrl.start_add_sub_fp = !is_mul; // The adder also handles FSUB.
                ctrl.sub_fp           = is_sub;
                state_d               = FP_WAIT;
            end
            FP_WAIT: begin
                state_d = FP_WAIT;
                if (done_fp) begin
                    ctrl.load_alu_fp = 1'b1; // Capture the unit result.
                    state_d          = FINISH;
                end
            end
            FINISH: begin
                ctrl.load_fp_regfile = 1'b1;
                ctrl.load_pc         = 1'b1;
                done                 = 1'b1;
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

/* hw/fsm_load_store.sv */
module fsm_load_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [31:0]          insn_q,
    input  logic                 memory_done,
    output ctrl_pkg::ctrl_word_t ctrl,
    output logic                 done
);
    import ctrl_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        ADDRESS,
        MEM_REQ,
        MEM_WAIT,
        FINISH
    } state_e;

    state_e  state_q;
    state_e  state;
    state_e  state_d;
    opcode_e opcode;
    logic    is_store;

    assign opcode   = opcode_e'(insn_q[6:0]);
    assign is_store = (opcode == STORE) || (opcode == STORE_FP);
    assign state    = (state_q == IDLE && start) ? DECODE : state_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = IDLE;
        ctrl    = '0;
        done    = 1'b0;
        case (state)
            DECODE: begin
                ctrl.load_rs1    = 1'b1; // Base address is always an integer register.
                ctrl.load_imm    = 1'b1;
                ctrl.load_rs2    = opcode == STORE;
                ctrl.load_rs2_fp = opcode == STORE_FP;
                state_d          = ADDRESS;
            end
            ADDRESS: begin
                ctrl.load_alu = 1'b1;
                state_d       = MEM_REQ;
            end
            MEM_REQ: begin
                ctrl.memory_start      = 1'b1;
                ctrl.sel_mem_operation = is_store; // High selects a write.
                state_d                = MEM_WAIT;
            end
            MEM_WAIT: begin
                state_d = MEM_WAIT; // Memory latency is not fixed.
                if (memory_done) begin
                    ctrl.load_data_memory = !is_store;
                    state_d               = FINISH;
                end
            end
            FINISH: begin
                ctrl.load_pc = 1'b1;
                done         = 1'b1;
                if (opcode == LOAD) begin
                    ctrl.load_regfile = 1'b1;
                    ctrl.sel_rd       = SEL_RD_MEM;
                end
                if (opcode == LOAD_FP) begin
                    ctrl.load_fp_regfile = 1'b1;
                    ctrl.sel_rd_fp       = 1'b1;
                end
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

/* hw/insn_classifier.sv */
module insn_classifier (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dispatch,
    input  logic [31:0]                   insn,
    input  logic                          done,
    output logic [ctrl_pkg::NUM_UNITS-1:0] start,
    output logic [31:0]                   insn_q,
    output logic                          illegal
);
    import ctrl_pkg::*;

    logic                 accept;
    logic [NUM_UNITS-1:0] start_d;

    assign accept = dispatch && !(|start); // Ignored while a unit is busy.

    always_comb begin
        start_d = '0;
        case (opcode_e'(insn[6:0]))
            OP, OP_IMM:                     start_d[UNIT_ALU] = 1'b1;
            BRANCH, JAL, JALR:              start_d[UNIT_BJ]  = 1'b1;
            LOAD, STORE, LOAD_FP, STORE_FP: start_d[UNIT_LS]  = 1'b1;
            OP_FP:   start_d[UNIT_FP] = insn[31:25] inside {FADD, FSUB, FMUL};
            default: start_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start   <= '0;
            illegal <= 1'b0;
        end else begin
            illegal <= accept && (start_d == '0);
            if (accept) begin
                start <= start_d;
            end else if (done) begin
                start <= '0; // The level drops as the unit finishes.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            insn_q <= insn;
        end
    end

endmodule
